// ==== rtl/packet_capture_buffer.sv ====
`timescale 1ns/1ps

module packet_capture_buffer import ts_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  ts_byte_t    ts_dly,
	input  logic        pkt_start,
	input  logic        hit,
	output logic        bank_full_pulse,
	output bank_t       full_bank,
	input  logic        bank_free,
	input  bank_t       free_bank,
	input  bank_t       rd_bank,
	input  word_idx_t   rd_addr,
	output word_t       rd_data,
	output logic [15:0] drop_count
);

	capture_state_e state_q;
	byte_cnt_t      byte_cnt_q;
	bank_t          wr_bank_q;
	logic [1:0]     full_q;

	word_t mem [2][TS_PACKET_WORDS];

	logic      start_ok;
	logic      drop;
	logic      wr_en;
	logic      last_byte;
	byte_cnt_t wr_pos;

	always_comb begin
		start_ok  = pkt_start && hit && !full_q[wr_bank_q];
		// Either no free bank or a partial packet cut short
		drop      = (pkt_start && hit && full_q[wr_bank_q]) ||
		            ((state_q == cap_fill) && pkt_start);
		wr_en     = start_ok || ((state_q == cap_fill) && ts_dly.valid && !pkt_start);
		wr_pos    = start_ok ? '0 : byte_cnt_q; // Start byte always lands at 0
		last_byte = wr_en && !start_ok &&
		            (byte_cnt_q == byte_cnt_t'(TS_PACKET_BYTES - 1));
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q         <= cap_idle;
			byte_cnt_q      <= '0;
			wr_bank_q       <= 1'b0;
			full_q          <= '0;
			bank_full_pulse <= 1'b0;
			full_bank       <= 1'b0;
			drop_count      <= '0;
		end else begin
			bank_full_pulse <= last_byte;
			if (drop) begin
				drop_count <= drop_count + 16'd1;
			end
			if (bank_free) begin
				full_q[free_bank] <= 1'b0;
			end
			if (start_ok) begin
				state_q    <= cap_fill;
				byte_cnt_q <= 8'd1;
			end else if (last_byte) begin
				state_q           <= cap_idle;
				byte_cnt_q        <= '0;
				full_q[wr_bank_q] <= 1'b1;
				full_bank         <= wr_bank_q;
				wr_bank_q         <= ~wr_bank_q; // Banks alternate
			end else if (wr_en) begin
				byte_cnt_q <= byte_cnt_q + 8'd1;
			end else if ((state_q == cap_fill) && pkt_start) begin
				state_q    <= cap_idle; // Abandoned, new one not wanted
				byte_cnt_q <= '0;
			end
		end
	end

	// Four bytes per word, first byte in the low lane
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_bank_q][wr_pos[7:2]][{wr_pos[1:0], 3'b000} +: 8] <= ts_dly.data;
		end
		rd_data <= mem[rd_bank][rd_addr];
	end

	a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
		byte_cnt_q <= byte_cnt_t'(TS_PACKET_BYTES - 1));

	a_free_full: assert property (@(posedge clk) disable iff (!rst_n)
		bank_free |-> full_q[free_bank]);

endmodule

// ==== rtl/packet_readout.sv ====
`timescale 1ns/1ps

module packet_readout import ts_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      bank_full_pulse,
	input  bank_t     full_bank,
	output logic      bank_free,
	output bank_t     free_bank,
	output bank_t     rd_bank,
	output word_idx_t rd_addr,
	input  word_t     rd_data,
	input  logic      credit_return,
	output logic      out_valid,
	output out_word_t out_word
);

	readout_state_e state_q;
	bank_t          q_bank [2];
	logic [1:0]     q_cnt;
	word_idx_t      iss_idx_q;
	word_idx_t      rd_idx_q;
	logic           iss_done_q;
	logic           rd_pend_q;
	credit_t        credit_q;

	credit_t inflight;
	logic    head_valid;
	bank_t   head_bank;
	logic    issue;
	logic    finish;

	always_comb begin
		// Fresh pulse bypasses an empty queue
		head_valid = (q_cnt != 2'd0) || bank_full_pulse;
		head_bank  = (q_cnt != 2'd0) ? q_bank[0] : full_bank;
		inflight   = credit_t'(rd_pend_q) + credit_t'(out_valid);
		issue      = head_valid && !iss_done_q && (credit_q > inflight);
		finish     = (state_q == ro_stream) && rd_pend_q &&
		             (rd_idx_q == word_idx_t'(TS_PACKET_WORDS - 1));
	end

	assign rd_bank = head_bank;
	assign rd_addr = iss_idx_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q    <= ro_idle;
			q_bank[0]  <= 1'b0;
			q_bank[1]  <= 1'b0;
			q_cnt      <= '0;
			iss_idx_q  <= '0;
			iss_done_q <= 1'b0;
			rd_pend_q  <= 1'b0;
			credit_q   <= credit_t'(OUT_CREDITS);
			out_valid  <= 1'b0;
			bank_free  <= 1'b0;
		end else begin
			rd_pend_q <= issue;
			out_valid <= rd_pend_q;
			credit_q  <= credit_q + credit_t'(credit_return) - credit_t'(out_valid);
			bank_free <= finish;

			case ({bank_full_pulse, finish})
				2'b10: begin
					q_bank[q_cnt[0]] <= full_bank;
					q_cnt            <= q_cnt + 2'd1;
				end
				2'b01: begin
					q_bank[0] <= q_bank[1];
					q_cnt     <= q_cnt - 2'd1;
				end
				2'b11: begin
					q_bank[0] <= (q_cnt == 2'd1) ? full_bank : q_bank[1];
					q_bank[1] <= full_bank;
				end
				default: begin
				end
			endcase

			if (issue) begin
				if (iss_idx_q == word_idx_t'(TS_PACKET_WORDS - 1)) begin
					iss_done_q <= 1'b1;
				end else begin
					iss_idx_q <= iss_idx_q + 6'd1;
				end
			end

			case (state_q)
				ro_idle: begin
					if (head_valid) begin
						state_q <= ro_stream;
					end
				end
				ro_stream: begin
					if (finish) begin
						state_q    <= ro_idle; // Last word back, bank done
						iss_idx_q  <= '0;
						iss_done_q <= 1'b0;
					end
				end
				default: begin
					state_q <= ro_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			rd_idx_q <= iss_idx_q;
		end
		if (rd_pend_q) begin
			out_word.data  <= rd_data;
			out_word.index <= rd_idx_q;
			out_word.last  <= (rd_idx_q == word_idx_t'(TS_PACKET_WORDS - 1));
		end
		if (finish) begin
			free_bank <= q_bank[0];
		end
	end

	a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
		credit_q <= credit_t'(OUT_CREDITS));

	a_valid_credit: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> (credit_q != '0));

endmodule

// ==== rtl/pid_filter_table.sv ====
`timescale 1ns/1ps

module pid_filter_table import ts_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     cfg_we,
	input  pid_cfg_t cfg,
	input  pid_idx_t cfg_rd_index,
	output pid_cfg_t cfg_rd,
	input  logic     match_enable,
	input  pid_t     pkt_pid,
	output logic     hit
);

	pid_t                   pid_q [PID_ENTRIES];
	logic [PID_ENTRIES-1:0] en_q;
	logic [PID_ENTRIES-1:0] match;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < PID_ENTRIES; i++) begin
				pid_q[i] <= '0;
			end
			en_q <= '0;
		end else if (cfg_we) begin
			pid_q[cfg.index] <= cfg.pid;
			en_q[cfg.index]  <= cfg.enable;
		end
	end

	// Index field echoes the request
	always_comb begin
		cfg_rd.index  = cfg_rd_index;
		cfg_rd.pid    = pid_q[cfg_rd_index];
		cfg_rd.enable = en_q[cfg_rd_index];
	end

	// All entries compared in parallel
	always_comb begin
		for (int i = 0; i < PID_ENTRIES; i++) begin
			match[i] = en_q[i] && (pid_q[i] == pkt_pid);
		end
	end

	assign hit = match_enable && (|match);

endmodule

// ==== rtl/ts_monitor_top.sv ====
`timescale 1ns/1ps

module ts_monitor_top import ts_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  ts_byte_t    ts_in,
	input  logic        match_enable,
	input  logic        cfg_we,
	input  pid_cfg_t    cfg,
	input  pid_idx_t    cfg_rd_index,
	output pid_cfg_t    cfg_rd,
	output logic        out_valid,
	output out_word_t   out_word,
	input  logic        credit_return,
	output logic [15:0] drop_count
);

	ts_byte_t  ts_dly;
	logic      pkt_start;
	pid_t      pkt_pid;
	logic      hit;
	logic      bank_full_pulse;
	bank_t     full_bank;
	logic      bank_free;
	bank_t     free_bank;
	bank_t     rd_bank;
	word_idx_t rd_addr;
	word_t     rd_data;

	ts_sync_detect i_sync (
		.clk       (clk),
		.rst_n     (rst_n),
		.ts_in     (ts_in),
		.ts_dly    (ts_dly),
		.pkt_start (pkt_start),
		.pkt_pid   (pkt_pid)
	);

	pid_filter_table i_filter (
		.clk          (clk),
		.rst_n        (rst_n),
		.cfg_we       (cfg_we),
		.cfg          (cfg),
		.cfg_rd_index (cfg_rd_index),
		.cfg_rd       (cfg_rd),
		.match_enable (match_enable),
		.pkt_pid      (pkt_pid),
		.hit          (hit)
	);

	packet_capture_buffer i_buffer (
		.clk             (clk),
		.rst_n           (rst_n),
		.ts_dly          (ts_dly),
		.pkt_start       (pkt_start),
		.hit             (hit),
		.bank_full_pulse (bank_full_pulse),
		.full_bank       (full_bank),
		.bank_free       (bank_free),
		.free_bank       (free_bank),
		.rd_bank         (rd_bank),
		.rd_addr         (rd_addr),
		.rd_data         (rd_data),
		.drop_count      (drop_count)
	);

	packet_readout i_readout (
		.clk             (clk),
		.rst_n           (rst_n),
		.bank_full_pulse (bank_full_pulse),
		.full_bank       (full_bank),
		.bank_free       (bank_free),
		.free_bank       (free_bank),
		.rd_bank         (rd_bank),
		.rd_addr         (rd_addr),
		.rd_data         (rd_data),
		.credit_return   (credit_return),
		.out_valid       (out_valid),
		.out_word        (out_word)
	);

endmodule

// ==== rtl/ts_pkg.sv ====
package ts_pkg;

	typedef logic [12:0] pid_t;
	typedef logic [1:0]  pid_idx_t;
	typedef logic [7:0]  byte_t;
	typedef logic [31:0] word_t;
	typedef logic [7:0]  byte_cnt_t; // 0 to 187
	typedef logic [5:0]  word_idx_t; // 0 to 46
	typedef logic [2:0]  credit_t;
	typedef logic        bank_t;

	localparam byte_t TS_SYNC_BYTE    = 8'h47;
	localparam int    TS_PACKET_BYTES = 188;
	localparam int    TS_PACKET_WORDS = 47;
	localparam int    PID_ENTRIES     = 4;
	localparam int    OUT_CREDITS     = 4;

	typedef struct packed {
		byte_t data;
		logic  valid;
		logic  sync;
	} ts_byte_t;

	typedef struct packed {
		pid_idx_t index;
		pid_t     pid;
		logic     enable;
	} pid_cfg_t;

	typedef struct packed {
		word_t     data;
		word_idx_t index;
		logic      last;
	} out_word_t;

	typedef enum logic {
		cap_idle,
		cap_fill
	} capture_state_e;

	typedef enum logic {
		ro_idle,
		ro_stream
	} readout_state_e;

endpackage

// ==== rtl/ts_sync_detect.sv ====
`timescale 1ns/1ps

module ts_sync_detect import ts_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  ts_byte_t ts_in,
	output ts_byte_t ts_dly,
	output logic     pkt_start,
	output pid_t     pkt_pid
);

	byte_t      data_q [3]; // Index 0 newest, 2 oldest
	logic [2:0] sync_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 3; i++) begin
				data_q[i] <= '0;
			end
			sync_q <= '0;
		end else if (ts_in.valid) begin
			data_q[0] <= ts_in.data;
			data_q[1] <= data_q[0];
			data_q[2] <= data_q[1];
			sync_q    <= {sync_q[1:0], ts_in.sync};
		end
	end

	// Oldest stage leaves on each valid input byte
	always_comb begin
		ts_dly.data  = data_q[2];
		ts_dly.valid = ts_in.valid;
		ts_dly.sync  = sync_q[2];
	end

	assign pkt_start = sync_q[2] && (data_q[2] == TS_SYNC_BYTE) && ts_in.valid;
	assign pkt_pid   = {data_q[1][4:0], data_q[0]}; // Header bytes 2 and 3

endmodule

// ==== run.sh ====
#!/bin/sh
set -e

verilator --binary --timing --assert -f src.f --top-module tb_ts_monitor -o tb_ts_monitor

# The simulation exits non-zero on a fatal error, the log decides the result
./obj_dir/tb_ts_monitor > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
	exit 1
fi
exit 0

// ==== src.f ====
rtl/ts_pkg.sv
rtl/ts_sync_detect.sv
rtl/pid_filter_table.sv
rtl/packet_capture_buffer.sv
rtl/packet_readout.sv
rtl/ts_monitor_top.sv
testbench/tb_ts_monitor.sv

// ==== testbench/tb_ts_monitor.sv ====
`timescale 1ns/1ps

module tb_ts_monitor import ts_pkg::*; ();

	logic        clk;
	logic        rst_n;
	ts_byte_t    ts_in;
	logic        match_enable;
	logic        cfg_we;
	pid_cfg_t    cfg;
	pid_idx_t    cfg_rd_index;
	pid_cfg_t    cfg_rd;
	logic        out_valid;
	out_word_t   out_word;
	logic        credit_return;
	logic [15:0] drop_count;

	logic [31:0]            lfsr;
	out_word_t              exp_q [$];
	out_word_t              rx_q [$];
	out_word_t              exp_word;
	logic                   exp_avail;
	pid_t                   model_pid [PID_ENTRIES];
	logic [PID_ENTRIES-1:0] model_en;
	logic                   cfg_ok;
	logic [13:0]            cfg_exp;
	logic [13:0]            cfg_act;
	logic                   hold_credits;
	int                     busy_banks;
	int                     exp_drops;
	int                     sent_cnt;
	int                     ret_cnt;

	ts_monitor_top i_dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.ts_in         (ts_in),
		.match_enable  (match_enable),
		.cfg_we        (cfg_we),
		.cfg           (cfg),
		.cfg_rd_index  (cfg_rd_index),
		.cfg_rd        (cfg_rd),
		.out_valid     (out_valid),
		.out_word      (out_word),
		.credit_return (credit_return),
		.drop_count    (drop_count)
	);

	always #20 clk = ~clk;

	// Taps 32, 22, 2, 1
	function automatic logic next_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], next_bit()};
		end
		return r;
	endfunction

	task automatic fail_stop();
		$display("test failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	// Scoreboard head, bank usage and credit counts move on the rising edge
	always @(posedge clk) begin
		if (rst_n) begin
			if (out_valid) begin
				if (exp_q.size() > 0) begin
					void'(exp_q.pop_front());
				end
				if (out_word.last) begin
					busy_banks--; // Bank released after its last word
				end
				sent_cnt++;
			end
			if (credit_return) begin
				ret_cnt++;
			end
		end
		exp_avail = (exp_q.size() > 0);
		exp_word  = exp_avail ? exp_q[0] : '0;
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < PID_ENTRIES; i++) begin
				model_pid[i] <= '0;
			end
			model_en <= '0;
			cfg_ok   <= 1'b1;
		end else begin
			if (cfg_we) begin
				model_pid[cfg.index] <= cfg.pid;
				model_en[cfg.index]  <= cfg.enable;
			end
			cfg_ok  <= (cfg_rd.pid == model_pid[cfg_rd_index]) &&
			           (cfg_rd.enable == model_en[cfg_rd_index]);
			cfg_exp <= {model_pid[cfg_rd_index], model_en[cfg_rd_index]};
			cfg_act <= {cfg_rd.pid, cfg_rd.enable};
		end
	end

	a_cfg_readback: assert property (@(negedge clk) disable iff (!rst_n) cfg_ok)
		else begin
			$display("Fail at %0t: cfg_rd expected %h got %h", $time, cfg_exp, cfg_act);
			fail_stop();
		end

	a_no_stray_word: assert property (@(negedge clk) disable iff (!rst_n)
		out_valid |-> exp_avail)
		else begin
			$display("A word came out at %0t while no packet was expected", $time);
			fail_stop();
		end

	a_word_match: assert property (@(negedge clk) disable iff (!rst_n)
		(out_valid && exp_avail) |-> (out_word == exp_word))
		else begin
			$display("Fail at %0t: out_word expected %h got %h", $time, exp_word, out_word);
			fail_stop();
		end

	a_credit_limit: assert property (@(negedge clk) disable iff (!rst_n)
		out_valid |-> (sent_cnt < OUT_CREDITS + ret_cnt))
		else begin
			$display("Fail at %0t: out_valid count expected at most %0d got %0d",
			         $time, OUT_CREDITS + ret_cnt, sent_cnt + 1);
			fail_stop();
		end

	// Consumer holds each word until it hands back a credit
	task automatic consumer_step();
		credit_return = 1'b0;
		if (out_valid) begin
			rx_q.push_back(out_word);
		end
		if ((rx_q.size() > 0) && !hold_credits) begin
			if (next_bit()) begin
				void'(rx_q.pop_front());
				credit_return = 1'b1;
			end
		end
	endtask

	task automatic tick();
		@(negedge clk);
		ts_in  = '0;
		cfg_we = 1'b0;
		consumer_step();
	endtask

	task automatic send_byte(input byte_t data, input logic sync);
		tick();
		while (next_bit()) begin
			tick(); // Valid gap
		end
		ts_in.data  = data;
		ts_in.valid = 1'b1;
		ts_in.sync  = sync;
	endtask

	task automatic send_packet(input pid_t pid, input byte_t start, input logic sync,
	                           input logic want_out);
		byte_t       bytes [TS_PACKET_BYTES];
		out_word_t   w;
		logic [31:0] r;
		r        = rand_bits(3);
		bytes[0] = start;
		bytes[1] = {r[2:0], pid[12:8]};
		bytes[2] = pid[7:0];
		for (int k = 3; k < TS_PACKET_BYTES; k++) begin
			bytes[k] = byte_t'(rand_bits(8));
		end
		if (want_out && (busy_banks >= 2)) begin
			exp_drops++;
		end else if (want_out) begin
			busy_banks++;
			for (int i = 0; i < TS_PACKET_WORDS; i++) begin
				w.data  = {bytes[4*i+3], bytes[4*i+2], bytes[4*i+1], bytes[4*i]};
				w.index = word_idx_t'(i);
				w.last  = (i == TS_PACKET_WORDS - 1);
				exp_q.push_back(w);
			end
		end
		for (int k = 0; k < TS_PACKET_BYTES; k++) begin
			send_byte(bytes[k], (k == 0) ? sync : 1'b0);
		end
	endtask

	// Pushes the tail of the last packet out of the sync delay chain
	task automatic flush();
		for (int i = 0; i < 3; i++) begin
			send_byte(8'h00, 1'b0);
		end
	endtask

	task automatic write_cfg(input pid_idx_t idx, input pid_t pid, input logic en);
		tick();
		cfg_we     = 1'b1;
		cfg.index  = idx;
		cfg.pid    = pid;
		cfg.enable = en;
		tick();
		cfg_rd_index = idx;
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while ((exp_q.size() != 0) || (rx_q.size() != 0)) begin
			if (n == 20000) begin
				$display("Timeout: %0d expected words never came out", exp_q.size());
				fail_stop();
			end
			tick();
			n++;
		end
	endtask

	task automatic wait_held(input int count);
		int n;
		n = 0;
		while (rx_q.size() < count) begin
			if (n == 5000) begin
				$display("Timeout: consumer got only %0d words while holding credits",
				         rx_q.size());
				fail_stop();
			end
			tick();
			n++;
		end
	endtask

	initial begin
		clk           = 1'b0;
		rst_n         = 1'b0;
		ts_in         = '0;
		match_enable  = 1'b0;
		cfg_we        = 1'b0;
		cfg           = '0;
		cfg_rd_index  = '0;
		credit_return = 1'b0;
		lfsr          = 32'h06a46e45;
		hold_credits  = 1'b0;
		busy_banks    = 0;
		exp_drops     = 0;
		sent_cnt      = 0;
		ret_cnt       = 0;
		repeat (16) tick();
		rst_n        = 1'b1;
		match_enable = 1'b1;

		write_cfg(2'd0, 13'h0100, 1'b1);
		write_cfg(2'd1, 13'h1abc, 1'b1);
		write_cfg(2'd2, 13'h0042, 1'b0);
		write_cfg(2'd3, 13'h1fff, 1'b1);
		for (int i = 0; i < PID_ENTRIES; i++) begin
			tick();
			cfg_rd_index = pid_idx_t'(i);
		end

		send_packet(13'h0100, TS_SYNC_BYTE, 1'b1, 1'b1);
		send_packet(13'h1abc, TS_SYNC_BYTE, 1'b1, 1'b1);
		flush();
		wait_drained();

		send_packet(13'h0555, TS_SYNC_BYTE, 1'b1, 1'b0); // No entry
		send_packet(13'h0042, TS_SYNC_BYTE, 1'b1, 1'b0); // Entry disabled
		send_packet(13'h1fff, 8'h46, 1'b1, 1'b0);
		send_packet(13'h1fff, TS_SYNC_BYTE, 1'b0, 1'b0); // Sync flag missing
		flush();
		tick();
		match_enable = 1'b0;
		send_packet(13'h0100, TS_SYNC_BYTE, 1'b1, 1'b0);
		flush();
		tick();
		match_enable = 1'b1;
		wait_drained();

		hold_credits = 1'b1;
		send_packet(13'h0100, TS_SYNC_BYTE, 1'b1, 1'b1);
		flush();
		wait_held(OUT_CREDITS);
		repeat (60) tick();
		hold_credits = 1'b0;
		wait_drained();

		// Third packet finds both banks full
		hold_credits = 1'b1;
		send_packet(13'h1abc, TS_SYNC_BYTE, 1'b1, 1'b1);
		send_packet(13'h0100, TS_SYNC_BYTE, 1'b1, 1'b1);
		send_packet(13'h1fff, TS_SYNC_BYTE, 1'b1, 1'b1);
		flush();
		wait_held(OUT_CREDITS);
		repeat (40) tick();
		hold_credits = 1'b0;
		wait_drained();
		repeat (4) tick();

		if (drop_count != 16'(exp_drops)) begin
			$display("Fail at %0t: drop_count expected %0d got %0d", $time, exp_drops, drop_count);
			fail_stop();
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule
